// File: Makefile
# Verilator build and run for the PS/2 mouse tracker

SIM       := verilator
SIM_FLAGS := --binary --timing -Wno-fatal
TOP       := mouse_tb
FILELIST  := mouse_tracker.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP), result taken from $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/mouse_tb.sv
// Testbench for the PS/2 mouse tracker
// Mouse model stimulus, Wishbone register checks against a reference model,
// and seven-segment scan checks

`timescale 1ns/1ps

module mouse_tb import mouse_pkg::*; ();

    // Upper bound on packet-sized events in the run
    localparam int     NUM_PACKETS = 60;
    localparam longint WATCHDOG_NS = longint'(NUM_PACKETS) * 100_000 + 2_000_000;
    localparam int     SEED        = 32'h2998_d21f;

    logic                 CLK_50MHZ;
    logic                 MASTER_RST;
    logic                 ps2_clk;
    logic                 ps2_data;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [1:0]           wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_i;
    logic [WB_DATA_W-1:0] wb_dat_o;
    logic                 wb_ack;
    logic [6:0]           seg;
    logic [3:0]           sel;

    // Reference model state
    logic [7:0]           exp_x;
    logic [7:0]           exp_y;
    logic [7:0]           exp_err;
    logic [4:0]           exp_pkts;
    logic [2:0]           exp_btn;
    logic [WB_DATA_W-1:0] last_status;

    // Stimulus and compare handshake
    event pkt_sent;
    event pkt_checked;

    mouse_top dut0 (
        .CLK_50MHZ  (CLK_50MHZ),
        .MASTER_RST (MASTER_RST),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .seg        (seg),
        .sel        (sel)
    );

    ps2_mouse_model mouse0 (
        .CLK_50MHZ (CLK_50MHZ),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data)
    );

    // 50 MHz
    initial begin
        CLK_50MHZ = 1'b0;
        forever #10 CLK_50MHZ = ~CLK_50MHZ;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the DUT stopped making progress",
                 WATCHDOG_NS);
        $display("Regression failed");
        $fatal(1, "Watchdog timeout");
    end

    // ==================================================================
    // Reference functions
    // ==================================================================

    // Saturating position update
    function automatic logic [7:0] clamp_pos(input logic [7:0] pos, input int delta);
        int sum;
        sum = int'(pos) + delta;
        if (sum < 0) begin
            return 8'd0;
        end
        if (sum > 255) begin
            return 8'd255;
        end
        return 8'(sum);
    endfunction

    // Active low with bit 0 as segment a
    function automatic logic [6:0] font_pattern(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'b100_0000;
            4'h1: return 7'b111_1001;
            4'h2: return 7'b010_0100;
            4'h3: return 7'b011_0000;
            4'h4: return 7'b001_1001;
            4'h5: return 7'b001_0010;
            4'h6: return 7'b000_0010;
            4'h7: return 7'b111_1000;
            4'h8: return 7'b000_0000;
            4'h9: return 7'b001_0000;
            4'hA: return 7'b000_1000;
            4'hB: return 7'b000_0011;
            4'hC: return 7'b100_0110;
            4'hD: return 7'b010_0001;
            4'hE: return 7'b000_0110;
            default: return 7'b000_1110;
        endcase
    endfunction

    function automatic logic [WB_DATA_W-1:0] status_word(input logic [7:0] errs,
                                                         input logic [4:0] pkts,
                                                         input logic [2:0] btn);
        return {errs, pkts, btn};
    endfunction

    function automatic int random_delta();
        return int'($urandom_range(511)) - 256;
    endfunction

    // ==================================================================
    // Compare and bus tasks
    // ==================================================================

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Check failed");
    endtask

    task automatic check_word(input logic [WB_DATA_W-1:0] got,
                              input logic [WB_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "Register mismatch");
        end
    endtask

    task automatic check_seg(input logic [6:0] got, input logic [6:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s shows %b, expected %b", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "Segment mismatch");
        end
    endtask

    task automatic wb_write(input wb_reg_e adr, input logic [WB_DATA_W-1:0] data);
        @(posedge CLK_50MHZ);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_i <= data;
        do @(negedge CLK_50MHZ); while (!wb_ack);
        @(posedge CLK_50MHZ);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    // Read data sampled mid-cycle while ack is high
    task automatic wb_read(input wb_reg_e adr, output logic [WB_DATA_W-1:0] data);
        @(posedge CLK_50MHZ);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        do @(negedge CLK_50MHZ); while (!wb_ack);
        data = wb_dat_o;
        @(posedge CLK_50MHZ);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // ==================================================================
    // Stimulus helpers
    // ==================================================================

    task automatic await_check();
        -> pkt_sent;
        @(pkt_checked);
    endtask

    // Sends bytes up to bad_pos with bad parity on that one
    // A bad_pos of -1 sends all three good bytes
    task automatic send_packet(input int dx, input int dy, input logic [2:0] btn,
                               input logic x_ovf, input logic y_ovf, input int bad_pos);
        logic [7:0] pkt_bytes [3];
        logic [8:0] dx9;
        logic [8:0] dy9;
        int         last;
        int         i;
        dx9 = 9'(dx);
        dy9 = 9'(dy);
        pkt_bytes[0] = {y_ovf, x_ovf, dy9[8], dx9[8], 1'b1, btn};
        pkt_bytes[1] = dx9[7:0];
        pkt_bytes[2] = dy9[7:0];
        last = (bad_pos < 0) ? 2 : bad_pos;
        for (i = 0; i <= last; i++) begin
            mouse0.send_byte(pkt_bytes[i], i == bad_pos);
        end
        if (bad_pos < 0) begin
            if (!x_ovf) begin
                exp_x = clamp_pos(exp_x, dx);
            end
            if (!y_ovf) begin
                exp_y = clamp_pos(exp_y, dy);
            end
            exp_btn  = btn;
            exp_pkts = exp_pkts + 5'd1;
        end else begin
            exp_err = exp_err + 8'd1;
        end
        await_check();
    endtask

    // Checks each digit and the rotation over four select steps
    task automatic check_scan(input logic [15:0] value, input string what);
        logic [3:0] prev_sel;
        int         digit;
        int         i;
        for (i = 0; i < 4; i++) begin
            @(negedge CLK_50MHZ);
            digit = 0;
            case (sel)
                4'b1110: digit = 0;
                4'b1101: digit = 1;
                4'b1011: digit = 2;
                4'b0111: digit = 3;
                default: report_failure("Digit select is not one-hot");
            endcase
            check_seg(seg, font_pattern(value[digit*4 +: 4]), what);
            prev_sel = sel;
            while (sel === prev_sel) @(negedge CLK_50MHZ);
            if (sel !== {prev_sel[2:0], prev_sel[3]}) begin
                report_failure("Digit select did not rotate left");
            end
        end
    endtask

    // ==================================================================
    // Compare process with one pass per packet or error event
    // ==================================================================

    initial begin : compare_proc
        logic [WB_DATA_W-1:0] status;
        logic [WB_DATA_W-1:0] pos;
        forever begin
            @(pkt_sent);
            // Poll until the count moves
            do begin
                wb_read(REG_STATUS, status);
            end while (status === last_status);
            check_word(status, status_word(exp_err, exp_pkts, exp_btn), "REG_STATUS");
            wb_read(REG_POS, pos);
            check_word(pos, {exp_y, exp_x}, "REG_POS");
            last_status = status;
            -> pkt_checked;
        end
    end

    initial begin : stimulus
        logic [WB_DATA_W-1:0] rd;
        logic [15:0]          value;
        int                   i;
        void'($urandom(SEED));
        MASTER_RST <= 1'b1;
        wb_cyc     <= 1'b0;
        wb_stb     <= 1'b0;
        wb_we      <= 1'b0;
        wb_adr     <= 2'd0;
        wb_dat_i   <= '0;
        exp_x       = POS_RESET;
        exp_y       = POS_RESET;
        exp_err     = 8'd0;
        exp_pkts    = 5'd0;
        exp_btn     = 3'd0;
        last_status = '0;
        repeat (4) @(posedge CLK_50MHZ);
        MASTER_RST <= 1'b0;

        // Reset state
        @(negedge CLK_50MHZ);
        if (sel !== 4'b1110) begin
            report_failure("Digit select is not 1110 after reset");
        end
        if (wb_ack !== 1'b0) begin
            report_failure("wb_ack is high before the first bus access");
        end
        wb_read(REG_POS, rd);
        check_word(rd, 16'h8080, "REG_POS after reset");
        wb_read(REG_STATUS, rd);
        check_word(rd, 16'h0000, "REG_STATUS after reset");

        // Random valid packets
        for (i = 0; i < 40; i++) begin
            send_packet(random_delta(), random_delta(), 3'($urandom_range(7)), 1'b0, 1'b0, -1);
        end

        // Pin both axes at each end and then hold one axis by overflow
        repeat (3) send_packet(255, -256, 3'b001, 1'b0, 1'b0, -1);
        repeat (3) send_packet(-256, 255, 3'b010, 1'b0, 1'b0, -1);
        send_packet(100, -60, 3'b100, 1'b1, 1'b0, -1);
        send_packet(70, 40, 3'b000, 1'b0, 1'b1, -1);

        // Header without bit 3 and then parity errors at each byte position
        mouse0.send_byte(8'($urandom) & 8'hF7, 1'b0);
        exp_err = exp_err + 8'd1;
        await_check();
        send_packet(random_delta(), random_delta(), 3'b011, 1'b0, 1'b0, -1);
        for (i = 0; i < 3; i++) begin
            send_packet(random_delta(), random_delta(), 3'b101, 1'b0, 1'b0, i);
            send_packet(random_delta(), random_delta(), 3'b110, 1'b0, 1'b0, -1);
        end

        // Display of a written value and then of the position
        value = 16'($urandom);
        wb_write(REG_DISP_CTRL, 16'(DISP_VALUE));
        wb_write(REG_DISP_VALUE, value);
        wb_read(REG_DISP_CTRL, rd);
        check_word(rd, 16'(DISP_VALUE), "REG_DISP_CTRL readback");
        wb_read(REG_DISP_VALUE, rd);
        check_word(rd, value, "REG_DISP_VALUE readback");
        check_scan(value, "seg in DISP_VALUE mode");
        wb_write(REG_DISP_CTRL, 16'(DISP_POS));
        check_scan({exp_y, exp_x}, "seg in DISP_POS mode");

        // Read-only register ignores writes
        wb_write(REG_POS, ~{exp_y, exp_x});
        wb_read(REG_POS, rd);
        check_word(rd, {exp_y, exp_x}, "REG_POS after write attempt");

        $display("Regression passed");
        $finish;
    end

endmodule

// File: dv/ps2_mouse_model.sv
// Behavioral PS/2 mouse for the tracker testbench
// Sends device-to-host frames with a 2 us bit period, optional bad parity

`timescale 1ns/1ps

module ps2_mouse_model (
    input  logic CLK_50MHZ,
    output logic ps2_clk,
    output logic ps2_data
);

    // 2 us bit period at 50 MHz, clock low for half of it
    localparam int HALF_BIT    = 50;
    localparam int QUARTER_BIT = 25;
    // Idle gap between bytes
    localparam int BYTE_GAP    = 50;

    // Lines idle high
    initial begin
        ps2_clk  <= 1'b1;
        ps2_data <= 1'b1;
    end

    // One 11-bit frame: start, 8 data bits LSB first, odd parity, stop
    task automatic send_byte(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        logic        parity;
        int          i;
        parity = ~(^data) ^ bad_parity;
        frame  = {1'b1, parity, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            // Data changes while the clock is high
            @(posedge CLK_50MHZ);
            ps2_data <= frame[i];
            repeat (QUARTER_BIT) @(posedge CLK_50MHZ);
            // Host samples on this falling edge
            ps2_clk <= 1'b0;
            repeat (HALF_BIT) @(posedge CLK_50MHZ);
            ps2_clk <= 1'b1;
            repeat (QUARTER_BIT - 1) @(posedge CLK_50MHZ);
        end
        ps2_data <= 1'b1;
        repeat (BYTE_GAP) @(posedge CLK_50MHZ);
    endtask

endmodule

// File: logic/mouse_ctrl.sv
// Mouse control block
// Assembles three-byte movement packets, counts bad bytes,
// decodes the Wishbone slave registers and picks the display source

`timescale 1ns/1ps

module mouse_ctrl import mouse_pkg::*; (
    input  logic                 CLK_50MHZ,
    input  logic                 MASTER_RST,
    input  logic                 byte_valid,
    input  logic [7:0]           rx_byte,
    input  logic                 frame_err,
    mouse_pkt_if.ctrl            pkt,
    input  logic [7:0]           pos_x,
    input  logic [7:0]           pos_y,
    input  logic [2:0]           buttons,
    input  logic [4:0]           pkt_count,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  wb_reg_e              wb_adr,
    input  logic [WB_DATA_W-1:0] wb_dat_i,
    output logic [WB_DATA_W-1:0] wb_dat_o,
    output logic                 wb_ack,
    output logic [15:0]          disp_value
);

    pkt_state_e            state;
    logic [7:0]            byte0;
    logic [7:0]            byte1;
    logic [7:0]            err_count;
    disp_mode_e            disp_mode;
    logic [15:0]           value_reg;
    logic [WB_DATA_W-1:0]  pos_word;
    logic [WB_DATA_W-1:0]  status_word;
    logic                  wb_req;

    // ==================================================================
    // Packet assembly FSM
    // ==================================================================

    always_ff @(posedge CLK_50MHZ or posedge MASTER_RST) begin
        if (MASTER_RST) begin
            state         <= PKT_IDLE;
            err_count     <= '0;
            pkt.pkt_valid <= 1'b0;
        end else begin
            pkt.pkt_valid <= 1'b0;
            if (byte_valid) begin
                case (state)
                    PKT_IDLE: begin
                        // Byte 0 always has bit 3 set so anything else is noise
                        if (frame_err || !rx_byte[3]) begin
                            err_count <= err_count + 8'd1;
                        end else begin
                            state <= PKT_BYTE1;
                        end
                    end
                    PKT_BYTE1: begin
                        if (frame_err) begin
                            err_count <= err_count + 8'd1;
                        end
                        state <= frame_err ? PKT_IDLE : PKT_BYTE2;
                    end
                    PKT_BYTE2: begin
                        if (frame_err) begin
                            err_count <= err_count + 8'd1;
                        end else begin
                            pkt.pkt_valid <= 1'b1;
                        end
                        state <= PKT_IDLE;
                    end
                    default: state <= PKT_IDLE;
                endcase
            end
        end
    end

    // Packet payload qualified by pkt_valid
    always_ff @(posedge CLK_50MHZ) begin
        if (byte_valid && state == PKT_IDLE) begin
            byte0 <= rx_byte;
        end
        if (byte_valid && state == PKT_BYTE1) begin
            byte1 <= rx_byte;
        end
        if (byte_valid && state == PKT_BYTE2) begin
            // Byte 0 bits are Yovf Xovf Ysign Xsign 1 M R L
            pkt.buttons <= byte0[2:0];
            pkt.dx      <= {byte0[4], byte1};
            pkt.dy      <= {byte0[5], rx_byte};
            pkt.x_ovf   <= byte0[6];
            pkt.y_ovf   <= byte0[7];
        end
    end

    // ==================================================================
    // Wishbone classic slave
    // ==================================================================

    assign pos_word    = {pos_y, pos_x};
    assign status_word = {err_count, pkt_count, buttons};

    // New request only when ack is low for the one-cycle gap
    assign wb_req = wb_cyc & wb_stb & ~wb_ack;

    always_ff @(posedge CLK_50MHZ or posedge MASTER_RST) begin
        if (MASTER_RST) begin
            wb_ack    <= 1'b0;
            disp_mode <= DISP_POS;
        end else begin
            wb_ack <= wb_req;
            if (wb_req && wb_we && wb_adr == REG_DISP_CTRL) begin
                disp_mode <= disp_mode_e'(wb_dat_i[1:0]);
            end
        end
    end

    // Value register and read data
    always_ff @(posedge CLK_50MHZ) begin
        if (wb_req && wb_we && wb_adr == REG_DISP_VALUE) begin
            value_reg <= wb_dat_i;
        end
        if (wb_req) begin
            case (wb_adr)
                REG_POS:        wb_dat_o <= pos_word;
                REG_STATUS:     wb_dat_o <= status_word;
                REG_DISP_CTRL:  wb_dat_o <= {14'd0, disp_mode};
                REG_DISP_VALUE: wb_dat_o <= value_reg;
                default:        wb_dat_o <= '0;
            endcase
        end
    end

    // Unknown mode codes fall back to the position
    always_comb begin
        case (disp_mode)
            DISP_STATUS: disp_value = status_word;
            DISP_VALUE:  disp_value = value_reg;
            default:     disp_value = pos_word;
        endcase
    end

endmodule

// File: logic/mouse_pkg.sv
// Shared definitions for the PS/2 mouse tracker
// Timing constants, FSM and display enums, Wishbone register map

package mouse_pkg;

    // ==================================================================
    // Widths and timing constants
    // ==================================================================

    // Wishbone data bus width
    localparam int WB_DATA_W = 16;

    // X and Y start in the middle of the range
    localparam logic [7:0] POS_RESET = 8'h80;

    // 100 us at 50 MHz without a PS/2 clock edge drops a partial frame
    localparam int RX_IDLE_TIMEOUT = 5000;
    localparam int RX_IDLE_W = $clog2(RX_IDLE_TIMEOUT);

    // Cycles each digit stays selected
    localparam int SCAN_PERIOD = 256;
    localparam int SCAN_CNT_W = $clog2(SCAN_PERIOD);

    // ==================================================================
    // Enums
    // ==================================================================

    // Packet assembly, named after the byte being waited for
    typedef enum logic [1:0] {
        PKT_IDLE  = 2'd0,
        PKT_BYTE1 = 2'd1,
        PKT_BYTE2 = 2'd2
    } pkt_state_e;

    // Display source select
    typedef enum logic [1:0] {
        DISP_POS    = 2'd0,
        DISP_STATUS = 2'd1,
        DISP_VALUE  = 2'd2
    } disp_mode_e;

    // Register word addresses
    // POS: {Y, X}, read only
    // STATUS: {err_count, pkt_count, buttons}, read only
    // DISP_CTRL: mode in [1:0]; DISP_VALUE: 16-bit value
    typedef enum logic [1:0] {
        REG_POS        = 2'd0,
        REG_STATUS     = 2'd1,
        REG_DISP_CTRL  = 2'd2,
        REG_DISP_VALUE = 2'd3
    } wb_reg_e;

endpackage

// File: logic/mouse_pkt_if.sv
// Decoded movement packet from the control block to the accumulator
// No ready signal, the accumulator takes every pulse

`timescale 1ns/1ps

interface mouse_pkt_if;

    // One-cycle strobe, fields valid with it
    logic              pkt_valid;
    // Left, right, middle from byte 0
    logic [2:0]        buttons;
    // Sign bit from byte 0, magnitude from byte 1 or 2
    logic signed [8:0] dx;
    logic signed [8:0] dy;
    // Overflow flags, an axis with its flag set is not moved
    logic              x_ovf;
    logic              y_ovf;

    modport ctrl  (output pkt_valid, buttons, dx, dy, x_ovf, y_ovf);
    modport accum (input  pkt_valid, buttons, dx, dy, x_ovf, y_ovf);

endinterface

// File: logic/mouse_top.sv
// PS/2 mouse tracker top level
// PS/2 receiver, packet control, position accumulator and display scan,
// with a plain Wishbone classic slave port

`timescale 1ns/1ps

module mouse_top import mouse_pkg::*; (
    input  logic                 CLK_50MHZ,
    input  logic                 MASTER_RST,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [1:0]           wb_adr,
    input  logic [WB_DATA_W-1:0] wb_dat_i,
    output logic [WB_DATA_W-1:0] wb_dat_o,
    output logic                 wb_ack,
    output logic [6:0]           seg,
    output logic [3:0]           sel
);

    // Byte path
    logic        byte_valid;
    logic [7:0]  rx_byte;
    logic        frame_err;

    // Position return
    logic [7:0]  pos_x;
    logic [7:0]  pos_y;
    logic [2:0]  buttons;
    logic [4:0]  pkt_count;

    logic [15:0] disp_value;

    // Control to accumulator
    mouse_pkt_if pkt_if ();

    ps2_rx u_ps2_rx (
        .CLK_50MHZ  (CLK_50MHZ),
        .MASTER_RST (MASTER_RST),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .frame_err  (frame_err)
    );

    mouse_ctrl u_mouse_ctrl (
        .CLK_50MHZ  (CLK_50MHZ),
        .MASTER_RST (MASTER_RST),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .frame_err  (frame_err),
        .pkt        (pkt_if.ctrl),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .buttons    (buttons),
        .pkt_count  (pkt_count),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_reg_e'(wb_adr)),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .disp_value (disp_value)
    );

    pos_accum u_pos_accum (
        .CLK_50MHZ  (CLK_50MHZ),
        .MASTER_RST (MASTER_RST),
        .pkt        (pkt_if.accum),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .buttons    (buttons),
        .pkt_count  (pkt_count)
    );

    seg_scan u_seg_scan (
        .CLK_50MHZ  (CLK_50MHZ),
        .MASTER_RST (MASTER_RST),
        .disp_value (disp_value),
        .seg        (seg),
        .sel        (sel)
    );

endmodule

// File: logic/pos_accum.sv
// Position accumulator
// Adds signed packet deltas to X/Y with clamping to 0..255,
// latches the buttons and counts accepted packets

`timescale 1ns/1ps

module pos_accum import mouse_pkg::*; (
    input  logic       CLK_50MHZ,
    input  logic       MASTER_RST,
    mouse_pkt_if.accum pkt,
    output logic [7:0] pos_x,
    output logic [7:0] pos_y,
    output logic [2:0] buttons,
    output logic [4:0] pkt_count
);

    logic [7:0] next_x;
    logic [7:0] next_y;

    // Signed 10-bit add, saturate at either end
    function automatic logic [7:0] clamp_add(
        input logic [7:0]        pos,
        input logic signed [8:0] delta
    );
        logic signed [9:0] sum;
        sum = $signed({2'b00, pos}) + delta;
        if (sum < 0) begin
            return 8'h00;
        end else if (sum > 10'sd255) begin
            return 8'hFF;
        end else begin
            return sum[7:0];
        end
    endfunction

    // Overflowed axis holds its position
    assign next_x = pkt.x_ovf ? pos_x : clamp_add(pos_x, pkt.dx);
    assign next_y = pkt.y_ovf ? pos_y : clamp_add(pos_y, pkt.dy);

    // ==================================================================
    // Position, buttons and packet count
    // ==================================================================

    always_ff @(posedge CLK_50MHZ or posedge MASTER_RST) begin
        if (MASTER_RST) begin
            pos_x     <= POS_RESET;
            pos_y     <= POS_RESET;
            buttons   <= '0;
            pkt_count <= '0;
        end else if (pkt.pkt_valid) begin
            pos_x     <= next_x;
            pos_y     <= next_y;
            buttons   <= pkt.buttons;
            // Wraps at 32
            pkt_count <= pkt_count + 5'd1;
        end
    end

endmodule

// File: logic/ps2_rx.sv
// PS/2 device-to-host serial receiver
// Synchronizes the pins, shifts one 11-bit frame on falling clock edges,
// then presents the byte with a framing/parity error flag for one cycle

`timescale 1ns/1ps

module ps2_rx import mouse_pkg::*; (
    input  logic       CLK_50MHZ,
    input  logic       MASTER_RST,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       byte_valid,
    output logic [7:0] rx_byte,
    output logic       frame_err
);

    // Synchronizer stages, lines idle high
    logic clk_meta;
    logic clk_sync;
    logic clk_prev;
    logic data_meta;
    logic data_sync;
    logic clk_fall;

    // Frame: start, d0..d7, parity, stop, LSB arrives first
    logic [10:0]          shreg;
    logic [3:0]           bit_cnt;
    logic [RX_IDLE_W-1:0] idle_cnt;
    logic                 idle_expired;

    // ==================================================================
    // Pin synchronizers and edge detect
    // ==================================================================

    always_ff @(posedge CLK_50MHZ or posedge MASTER_RST) begin
        if (MASTER_RST) begin
            clk_meta  <= 1'b1;
            clk_sync  <= 1'b1;
            clk_prev  <= 1'b1;
            data_meta <= 1'b1;
            data_sync <= 1'b1;
        end else begin
            clk_meta  <= ps2_clk;
            clk_sync  <= clk_meta;
            clk_prev  <= clk_sync;
            data_meta <= ps2_data;
            data_sync <= data_meta;
        end
    end

    // Data and clock share the same delay, so data is stable here
    assign clk_fall = clk_prev & ~clk_sync;

    // ==================================================================
    // Frame shift and idle timeout
    // ==================================================================

    assign idle_expired = (idle_cnt == RX_IDLE_W'(RX_IDLE_TIMEOUT - 1));

    always_ff @(posedge CLK_50MHZ or posedge MASTER_RST) begin
        if (MASTER_RST) begin
            bit_cnt  <= '0;
            idle_cnt <= '0;
        end else if (bit_cnt == 4'd11) begin
            // Frame presented for one cycle, start over
            bit_cnt  <= '0;
            idle_cnt <= '0;
        end else if (clk_fall) begin
            bit_cnt  <= bit_cnt + 4'd1;
            idle_cnt <= '0;
        end else if (bit_cnt != 4'd0) begin
            // Mid-frame, watch for a stalled mouse
            if (idle_expired) begin
                bit_cnt  <= '0;
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // Payload only, qualified by bit_cnt
    always_ff @(posedge CLK_50MHZ) begin
        if (clk_fall) begin
            shreg <= {data_sync, shreg[10:1]};
        end
    end

    // Full frame sits in shreg while bit_cnt is 11
    assign byte_valid = (bit_cnt == 4'd11);
    assign rx_byte    = shreg[8:1];
    // Start must be 0, stop must be 1, odd parity over data plus parity
    assign frame_err  = shreg[0] | ~shreg[10] | ~(^shreg[9:1]);

endmodule

// File: logic/seg_scan.sv
// Four-digit multiplexed seven-segment driver
// Rotates an active-low digit select on a scan strobe, hex font inside

`timescale 1ns/1ps

module seg_scan import mouse_pkg::*; (
    input  logic        CLK_50MHZ,
    input  logic        MASTER_RST,
    input  logic [15:0] disp_value,
    output logic [6:0]  seg,
    output logic [3:0]  sel
);

    logic [SCAN_CNT_W-1:0] scan_cnt;
    logic                  scan_stb;
    logic [3:0]            nibble;
    logic                  sel_ok;

    // Active high pattern, bit 0 is segment a, bit 6 is segment g
    function automatic logic [6:0] hex_font(input logic [3:0] val);
        case (val)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    // Scan strobe, one cycle every SCAN_PERIOD
    assign scan_stb = (scan_cnt == SCAN_CNT_W'(SCAN_PERIOD - 1));

    always_ff @(posedge CLK_50MHZ or posedge MASTER_RST) begin
        if (MASTER_RST) begin
            scan_cnt <= '0;
            sel      <= 4'b1110;
        end else begin
            scan_cnt <= scan_stb ? '0 : scan_cnt + 1'b1;
            // Rotate left: 1110, 1101, 1011, 0111
            if (scan_stb) begin
                sel <= {sel[2:0], sel[3]};
            end
        end
    end

    // Digit 0 is the low nibble
    always_comb begin
        sel_ok = 1'b1;
        case (sel)
            4'b1110: nibble = disp_value[3:0];
            4'b1101: nibble = disp_value[7:4];
            4'b1011: nibble = disp_value[11:8];
            4'b0111: nibble = disp_value[15:12];
            default: begin
                nibble = 4'h0;
                sel_ok = 1'b0;
            end
        endcase
    end

    // Segments are active low, blank on a bad select
    assign seg = sel_ok ? ~hex_font(nibble) : 7'h7F;

endmodule

// File: mouse_tracker.f
logic/mouse_pkg.sv
logic/mouse_pkt_if.sv
logic/ps2_rx.sv
logic/mouse_ctrl.sv
logic/pos_accum.sv
logic/seg_scan.sv
logic/mouse_top.sv
dv/ps2_mouse_model.sv
dv/mouse_tb.sv
